// ==== sources.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_baud_tick.sv
hdl/uart_transmitter.sv
hdl/uart_receiver.sv
hdl/uart_top.sv
tb/tb_clock_gen.sv
tb/tb_uart_top.sv

// ==== Makefile ====
# Verilator build and run of the UART testbench
VERILATOR ?= verilator
TOP ?= tb_uart_top
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timescale $(TIMESCALE)
PASS_MSG ?= Finished with no errors

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_uart_top.sv ====
// UART subsystem testbench
// Table-driven loopback and frame error rows followed by glitches on rxd
`include "uart_config.svh"

module tb_uart_top;
	timeunit 1ns;
	timeprecision 100ps;
	import uart_pkg::*;

	localparam int num_rows = 21;
	localparam int max_div = 10;
	localparam int divs [3] = '{1, 3, 10};
	localparam logic [7:0] fixed [4] = '{8'h00, 8'hFF, 8'h55, 8'hA5};
	// 12 bit times per row at the slowest divisor with each glitch counted as a row
	localparam longint wd_base = longint'(num_rows + 2) * 12 * 4 * (max_div + 1) * 100;

	logic iCLOCK;
	logic inRESET;
	logic [`UART_DIV_WIDTH-1:0] baud_div;
	tx_req_t tx_req;
	logic busy;
	logic txd;
	logic rxd;
	rx_byte_t rx_out;
	rx_byte_t last_rx;
	logic inject;
	logic inject_level;
	int valid_seen = 0;

	// Stimulus table
	string row_name [num_rows];
	int row_div [num_rows];
	logic [7:0] row_data [num_rows];
	logic row_inject [num_rows];
	logic row_exp_err [num_rows];

	tb_clock_gen u_clock_gen (.iCLOCK(iCLOCK), .inRESET(inRESET));

	// Loopback unless the testbench owns the line
	assign rxd = inject ? inject_level : txd;

	uart_top u_dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.baud_div(baud_div),
		.tx_req(tx_req),
		.busy(busy),
		.txd(txd),
		.rxd(rxd),
		.rx_out(rx_out)
	);

	// Count result strobes and keep the last one
	always @(posedge iCLOCK) begin
		if (rx_out.valid) begin
			valid_seen <= valid_seen + 1;
			last_rx <= rx_out;
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			stop_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", name, exp, act));
		end
	endtask

	// Galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Clocks spent before txd shows level
	task automatic wait_txd(input logic level, input int limit, output int n);
		n = 0;
		while (txd !== level) begin
			if (n > limit) begin
				stop_run("txd did not change level within the expected time");
			end else begin
				n++;
				@(posedge iCLOCK);
			end
		end
	endtask

	task automatic send_loopback(input int i);
		int p;
		int n;
		p = row_div[i] + 1;
		@(posedge iCLOCK);
		tx_req <= '{strobe: 1'b1, data: row_data[i]};
		@(posedge iCLOCK);
		tx_req <= '{strobe: 1'b0, data: 8'h00};
		@(posedge iCLOCK);
		// Already busy so this strobe is dropped
		check_value({row_name[i], " busy"}, 1, 32'(busy));
		tx_req <= '{strobe: 1'b1, data: ~row_data[i]};
		@(posedge iCLOCK);
		tx_req <= '{strobe: 1'b0, data: 8'h00};
		wait_txd(1'b0, 2 * p, n);
		wait_txd(1'b1, 40 * p, n);
		// Low run is the start bit alone only if bit 0 is 1
		if (row_data[i][0]) begin
			check_value({row_name[i], " start_bit"}, 4 * p, n);
		end
		n = 0;
		while (busy) begin
			if (n > 44 * p) begin
				stop_run("busy stayed high past the end of the frame");
			end else begin
				n++;
				@(posedge iCLOCK);
			end
		end
	endtask

	// Start bit and data LSB first with the stop level from the row
	task automatic drive_frame(input int i);
		logic [9:0] frame;
		frame = {~row_exp_err[i], row_data[i], 1'b0};
		for (int b = 0; b < 10; b++) begin
			inject_level <= frame[b];
			repeat (4 * (row_div[i] + 1)) @(posedge iCLOCK);
		end
		inject_level <= 1'b1;
	endtask

	initial begin
		#(wd_base + wd_base / 10);
		stop_run($sformatf("Timeout, tests still running after %0d ns", wd_base + wd_base / 10));
	end

	initial begin
		logic [15:0] lfsr;
		int base;
		baud_div = `UART_DIV_WIDTH'(1);
		tx_req = '0;
		inject = 1'b0;
		inject_level = 1'b1;
		// Fixed bytes at each divisor then LFSR bytes then a bad stop bit
		for (int r = 0; r < 12; r++) begin
			row_div[r] = divs[r % 3];
			row_data[r] = fixed[r / 3];
			row_inject[r] = 1'b0;
			row_exp_err[r] = 1'b0;
		end
		lfsr = 16'd77;
		for (int r = 12; r < 20; r++) begin
			for (int b = 0; b < 8; b++) begin
				row_data[r][b] = lfsr[0];
				lfsr = lfsr_step(lfsr);
			end
			row_div[r] = divs[r % 3];
			row_inject[r] = 1'b0;
			row_exp_err[r] = 1'b0;
		end
		row_div[20] = 3;
		row_data[20] = 8'h3C;
		row_inject[20] = 1'b1;
		row_exp_err[20] = 1'b1;
		for (int r = 0; r < num_rows; r++) begin
			row_name[r] = $sformatf("row%0d_div%0d_%02h", r, row_div[r], row_data[r]);
		end

		wait (inRESET === 1'b1);
		@(posedge iCLOCK);
		check_value("reset busy", 0, 32'(busy));
		check_value("reset txd", 1, 32'(txd));
		repeat (20) @(posedge iCLOCK);
		check_value("reset valid_count", 0, 32'(valid_seen));

		for (int i = 0; i < num_rows; i++) begin
			base = valid_seen;
			@(posedge iCLOCK);
			baud_div <= `UART_DIV_WIDTH'(row_div[i]);
			inject <= row_inject[i];
			if (row_inject[i]) begin
				drive_frame(i);
			end else begin
				send_loopback(i);
			end
			// One bit time after the frame ends
			repeat (4 * (row_div[i] + 1)) @(posedge iCLOCK);
			check_value({row_name[i], " valid_count"}, 1, 32'(valid_seen - base));
			check_value({row_name[i], " data"}, 32'(row_data[i]), 32'(last_rx.data));
			check_value({row_name[i], " frame_err"}, 32'(row_exp_err[i]),
				32'(last_rx.frame_err));
		end

		// Low pulses one clock shorter than a tick period
		// Pulse starts differ by a non-multiple of the tick period so one pulse meets a tick
		base = valid_seen;
		@(posedge iCLOCK);
		baud_div <= `UART_DIV_WIDTH'(max_div);
		inject <= 1'b1;
		for (int g = 0; g < 2; g++) begin
			inject_level <= 1'b0;
			repeat (max_div) @(posedge iCLOCK);
			inject_level <= 1'b1;
			repeat (48 * (max_div + 1)) @(posedge iCLOCK);
		end
		check_value("glitch valid_count", 0, 32'(valid_seen - base));

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 16 cycles
module tb_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	// Release on a rising edge
	initial begin
		inRESET = 1'b0;
		repeat (16) @(posedge iCLOCK);
		inRESET <= 1'b1;
	end

endmodule

// ==== hdl/uart_top.sv ====
// UART subsystem top
// Shared baud tick feeding the transmitter and receiver, serial pins out
`include "uart_config.svh"

module uart_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic [`UART_DIV_WIDTH-1:0] baud_div,
	input uart_pkg::tx_req_t tx_req,
	output logic busy,
	output logic txd,
	input logic rxd,
	output uart_pkg::rx_byte_t rx_out
);
	import uart_pkg::*;

	// One time base for both directions
	logic tick;

	uart_baud_tick u_baud_tick (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.baud_div(baud_div),
		.tick(tick)
	);

	uart_transmitter u_transmitter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.tick(tick),
		.tx_req(tx_req),
		.busy(busy),
		.txd(txd)
	);

	// rxd is asynchronous, synchronized inside
	uart_receiver u_receiver (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.tick(tick),
		.rxd(rxd),
		.rx_out(rx_out)
	);

endmodule

// ==== hdl/uart_receiver.sv ====
// UART byte receiver
// Synchronizes rxd, validates the start bit at mid-bit, samples data and stop
`include "uart_config.svh"

module uart_receiver (
	input logic iCLOCK,
	input logic inRESET,
	input logic tick,
	input logic rxd,
	output uart_pkg::rx_byte_t rx_out
);
	import uart_pkg::*;

	localparam int unsigned os_w = $clog2(`UART_OVERSAMPLE);
	localparam int unsigned idx_w = $clog2(`UART_DATA_WIDTH);
	localparam logic [os_w-1:0] os_last = os_w'(`UART_OVERSAMPLE - 1);
	localparam logic [os_w-1:0] os_mid = os_w'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [idx_w-1:0] idx_last = idx_w'(`UART_DATA_WIDTH - 1);

	rx_state_e state;
	logic rxd_meta;
	logic rxd_sync;
	logic [os_w-1:0] sub_cnt;
	logic [idx_w-1:0] bit_idx;
	logic [`UART_DATA_WIDTH-1:0] shift;
	logic [`UART_DATA_WIDTH-1:0] data_q;
	logic valid_q;
	logic err_q;
	logic bit_end;

	// Two-flop synchronizer, idle line is high
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	// Sample point, four ticks after the previous one
	assign bit_end = tick && (sub_cnt == os_last);

	// Frame FSM and result strobe
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= rx_idle;
			sub_cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				rx_idle: begin
					sub_cnt <= '0;
					bit_idx <= '0;
					// Low at a tick starts a frame candidate
					if (tick && !rxd_sync) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					if (tick) begin
						if (sub_cnt == os_mid) begin
							sub_cnt <= '0;
							// High at mid-bit means a glitch
							state <= rxd_sync ? rx_idle : rx_data;
						end else begin
							sub_cnt <= sub_cnt + 1'b1;
						end
					end
				end
				rx_data: begin
					if (tick) begin
						sub_cnt <= bit_end ? '0 : sub_cnt + 1'b1;
					end
					if (bit_end) begin
						if (bit_idx == idx_last) begin
							state <= rx_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				default: begin
					if (tick) begin
						sub_cnt <= bit_end ? '0 : sub_cnt + 1'b1;
					end
					// Stop sample, zero flags a framing error
					if (bit_end) begin
						valid_q <= 1'b1;
						err_q <= !rxd_sync;
						state <= rx_idle;
					end
				end
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge iCLOCK) begin
		if (state == rx_data && bit_end) begin
			shift <= {rxd_sync, shift[`UART_DATA_WIDTH-1:1]};
		end
		if (state == rx_stop && bit_end) begin
			data_q <= shift;
		end
	end

	always_comb begin
		rx_out.valid = valid_q;
		rx_out.frame_err = err_q;
		rx_out.data = data_q;
	end

endmodule

// ==== hdl/uart_transmitter.sv ====
// UART byte transmitter
// Request latch plus start, data and stop serializer at four ticks per bit
`include "uart_config.svh"

module uart_transmitter (
	input logic iCLOCK,
	input logic inRESET,
	input logic tick,
	input uart_pkg::tx_req_t tx_req,
	output logic busy,
	output logic txd
);
	import uart_pkg::*;

	localparam int unsigned os_w = $clog2(`UART_OVERSAMPLE);
	localparam int unsigned idx_w = $clog2(`UART_DATA_WIDTH);
	localparam logic [os_w-1:0] os_last = os_w'(`UART_OVERSAMPLE - 1);
	localparam logic [idx_w-1:0] idx_last = idx_w'(`UART_DATA_WIDTH - 1);

	tx_state_e state;
	logic [os_w-1:0] sub_cnt;
	logic [idx_w-1:0] bit_idx;
	logic [`UART_DATA_WIDTH-1:0] shadow;
	logic accept;
	logic bit_end;

	// Strobes while busy are dropped
	assign accept = tx_req.strobe && !busy;

	// Last tick of the current bit
	assign bit_end = tick && (sub_cnt == os_last);

	// Byte held for the whole frame
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			shadow <= tx_req.data;
		end
	end

	// Busy from accept until the last stop tick
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (state == tx_stop && bit_end) begin
			busy <= 1'b0;
		end
	end

	// Frame sequencer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= tx_idle;
			sub_cnt <= '0;
			bit_idx <= '0;
		end else if (state == tx_idle) begin
			sub_cnt <= '0;
			bit_idx <= '0;
			// Start bit begins on the first tick after the request
			if (busy && tick) begin
				state <= tx_start;
			end
		end else if (tick) begin
			sub_cnt <= bit_end ? '0 : sub_cnt + 1'b1;
			if (bit_end) begin
				case (state)
					tx_start: begin
						state <= tx_data;
					end
					tx_data: begin
						if (bit_idx == idx_last) begin
							state <= tx_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
					default: begin
						// End of stop bit
						state <= tx_idle;
					end
				endcase
			end
		end
	end

	// Line level from state and bit index
	always_comb begin
		case (state)
			tx_start: txd = 1'b0;
			tx_data: txd = shadow[bit_idx];
			default: txd = 1'b1;
		endcase
	end

endmodule

// ==== hdl/uart_baud_tick.sv ====
// UART baud tick generator
// One-clock enable every baud_div plus one clocks, shared by TX and RX
`include "uart_config.svh"

module uart_baud_tick (
	input logic iCLOCK,
	input logic inRESET,
	input logic [`UART_DIV_WIDTH-1:0] baud_div,
	output logic tick
);
	import uart_pkg::*;

	logic [`UART_DIV_WIDTH-1:0] count;

	// Wrap at the divisor
	// >= so a lowered divisor does not run the counter to full scale
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count >= baud_div) begin
			count <= '0;
			tick <= 1'b1;
		end else begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

// ==== hdl/uart_pkg.sv ====
// UART shared types
// FSM state encodings and the byte request and result structs
`include "uart_config.svh"

package uart_pkg;

	// Transmitter FSM, one state per frame section
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_e;

	// Receiver FSM, start state covers the mid-bit check
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_e;

	// Byte request, strobe high for one clock
	typedef struct packed {
		logic strobe;
		logic [`UART_DATA_WIDTH-1:0] data;
	} tx_req_t;

	// Received byte, valid is a one-clock strobe
	typedef struct packed {
		logic valid;
		logic frame_err;
		logic [`UART_DATA_WIDTH-1:0] data;
	} rx_byte_t;

endpackage

// ==== hdl/uart_config.svh ====
// UART build constants
// Divisor width, frame data width and ticks per bit
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Baud divisor width, tick period is divisor plus one clocks
`define UART_DIV_WIDTH 20

// Data bits per frame, sent LSB first
`define UART_DATA_WIDTH 8

// Baud ticks per serial bit
`define UART_OVERSAMPLE 4

`endif
